//--- rtl/gteRegPkg.sv
`default_nettype none

package gteRegPkg;

    // bank geometry
    localparam int RegCount = 32;
    localparam int RegIdxWidth = 5;
    localparam int DataWidth = 32;

    // data bank
    localparam logic [RegIdxWidth-1:0] IdxOtz = 5'd7;
    localparam logic [RegIdxWidth-1:0] IdxSxy0 = 5'd12;
    localparam logic [RegIdxWidth-1:0] IdxSxy1 = 5'd13;
    localparam logic [RegIdxWidth-1:0] IdxSxy2 = 5'd14;
    localparam logic [RegIdxWidth-1:0] IdxSz0 = 5'd16;
    localparam logic [RegIdxWidth-1:0] IdxSz1 = 5'd17;
    localparam logic [RegIdxWidth-1:0] IdxSz2 = 5'd18;
    localparam logic [RegIdxWidth-1:0] IdxSz3 = 5'd19;
    localparam logic [RegIdxWidth-1:0] IdxMac0 = 5'd24;

    // control bank
    localparam logic [RegIdxWidth-1:0] IdxZsf3 = 5'd29;
    localparam logic [RegIdxWidth-1:0] IdxZsf4 = 5'd30;

    // depth result scaling and limC ceiling
    localparam int OtzShift = 12;
    localparam logic [15:0] OtzMax = 16'h7FFF;

    // host address map, bits 6:5 pick data bank, control bank or command
    localparam int BusAdrWidth = 7;
    localparam logic [BusAdrWidth-1:0] CmdAdr = 7'd64;

endpackage

`default_nettype wire

//--- rtl/gteCmdPkg.sv
`default_nettype none

package gteCmdPkg;

    // opcode as written to the command register, bits 1:0
    typedef enum logic [1:0] {
        OpNone,
        OpAvsz3,
        OpAvsz4,
        OpNclip
    } gteOp;

    typedef enum logic [1:0] {
        StIdle,
        StRun,
        StWrite
    } seqState;

    // one product per cycle, so steps equal product count
    localparam int StepWidth = 3;
    localparam logic [StepWidth-1:0] StepsAvsz3 = 3'd3;
    localparam logic [StepWidth-1:0] StepsAvsz4 = 3'd4;
    localparam logic [StepWidth-1:0] StepsNclip = 3'd6;

endpackage

`default_nettype wire

//--- rtl/gteBusPort.sv
`default_nettype none

module gteBusPort (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  cyc,
    input  wire                                  stb,
    input  wire                                  we,
    input  wire  [gteRegPkg::BusAdrWidth-1:0]    adr,
    input  wire  [gteRegPkg::DataWidth-1:0]      datIn,
    input  wire                                  busy,
    input  wire  [gteRegPkg::DataWidth-1:0]      hostRdData,
    output logic [gteRegPkg::DataWidth-1:0]      datOut,
    output logic                                 ack,
    output logic                                 hostWe,
    output logic                                 hostBank,
    output logic [gteRegPkg::RegIdxWidth-1:0]    hostIdx,
    output logic [gteRegPkg::DataWidth-1:0]      hostData,
    output logic                                 cmdStart,
    output gteCmdPkg::gteOp                      cmdOp
);

    logic request;
    logic accept;
    logic isReg;
    logic isCmd;

    assign request = cyc && stb;
    // back-pressure: a pending request just waits out the command
    // and the !ack term keeps one beat from being taken twice
    assign accept = request && !ack && !busy;

    // bit 6 clear selects one of the banks, bit 5 picks which
    assign isReg = !adr[gteRegPkg::BusAdrWidth-1];
    assign isCmd = adr == gteRegPkg::CmdAdr;

    assign hostBank = adr[gteRegPkg::RegIdxWidth];
    assign hostIdx = adr[gteRegPkg::RegIdxWidth-1:0];
    assign hostData = datIn;
    assign hostWe = accept && we && isReg;

    // opcode rides in the low two data bits
    assign cmdOp = gteCmdPkg::gteOp'(datIn[1:0]);
    // OpNone is acked but starts nothing
    assign cmdStart = accept && we && isCmd && (cmdOp != gteCmdPkg::OpNone);

    // single cycle ack pulse, same edge as the write or command start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // read data lands with ack, command address and holes read zero
    always_ff @(posedge clk) begin
        if (accept && !we) begin
            datOut <= isReg ? hostRdData : '0;
        end
    end

    // an ack only ever answers a request still on the bus
    ackNeedsRequest: assert property (@(posedge clk) disable iff (rst)
        ack |-> (cyc && stb));

endmodule

`default_nettype wire

//--- rtl/gteRegFile.sv
`default_nettype none

module gteRegFile (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  hostWe,
    input  wire                                  hostBank,
    input  wire  [gteRegPkg::RegIdxWidth-1:0]    hostIdx,
    input  wire  [gteRegPkg::DataWidth-1:0]      hostData,
    output logic [gteRegPkg::DataWidth-1:0]      hostRdData,
    input  wire                                  resWe,
    input  wire                                  writeOtz,
    input  wire  [gteRegPkg::DataWidth-1:0]      mac0,
    input  wire  [15:0]                          otz,
    output logic [gteRegPkg::DataWidth-1:0]      sz0,
    output logic [gteRegPkg::DataWidth-1:0]      sz1,
    output logic [gteRegPkg::DataWidth-1:0]      sz2,
    output logic [gteRegPkg::DataWidth-1:0]      sz3,
    output logic [gteRegPkg::DataWidth-1:0]      sxy0,
    output logic [gteRegPkg::DataWidth-1:0]      sxy1,
    output logic [gteRegPkg::DataWidth-1:0]      sxy2,
    output logic [gteRegPkg::DataWidth-1:0]      zsf3,
    output logic [gteRegPkg::DataWidth-1:0]      zsf4
);

    // data bank holds vertices and results, control bank the scale factors
    logic [gteRegPkg::DataWidth-1:0] dataBank [gteRegPkg::RegCount];
    logic [gteRegPkg::DataWidth-1:0] ctrlBank [gteRegPkg::RegCount];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < gteRegPkg::RegCount; i++) begin
                dataBank[i] <= '0;
                ctrlBank[i] <= '0;
            end
        end else begin
            // host side, whole words only
            if (hostWe) begin
                if (hostBank) begin
                    ctrlBank[hostIdx] <= hostData;
                end else begin
                    dataBank[hostIdx] <= hostData;
                end
            end
            // result write-back from the datapath
            if (resWe) begin
                dataBank[gteRegPkg::IdxMac0] <= mac0;
                // otz zero-extended, nclip leaves it alone
                if (writeOtz) begin
                    dataBank[gteRegPkg::IdxOtz] <= gteRegPkg::DataWidth'(otz);
                end
            end
        end
    end

    assign hostRdData = hostBank ? ctrlBank[hostIdx] : dataBank[hostIdx];

    // operand taps
    assign sz0 = dataBank[gteRegPkg::IdxSz0];
    assign sz1 = dataBank[gteRegPkg::IdxSz1];
    assign sz2 = dataBank[gteRegPkg::IdxSz2];
    assign sz3 = dataBank[gteRegPkg::IdxSz3];
    assign sxy0 = dataBank[gteRegPkg::IdxSxy0];
    assign sxy1 = dataBank[gteRegPkg::IdxSxy1];
    assign sxy2 = dataBank[gteRegPkg::IdxSxy2];
    assign zsf3 = ctrlBank[gteRegPkg::IdxZsf3];
    assign zsf4 = ctrlBank[gteRegPkg::IdxZsf4];

    // bus stall and write-back must keep the two write ports apart
    noWriteClash: assert property (@(posedge clk) disable iff (rst)
        !(hostWe && resWe));

endmodule

`default_nettype wire

//--- rtl/gteSequencer.sv
`default_nettype none

module gteSequencer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cmdStart,
    input  var gteCmdPkg::gteOp cmdOp,
    input  wire                 lastStep,
    output logic                run,
    output logic                clearAcc,
    output logic                accEn,
    output logic                resWe,
    output logic                busy,
    output gteCmdPkg::gteOp     curOp
);

    gteCmdPkg::seqState state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= gteCmdPkg::StIdle;
            curOp <= gteCmdPkg::OpNone;
        end else begin
            case (state)
                gteCmdPkg::StIdle: begin
                    // opcode held for counter and datapath
                    if (cmdStart) begin
                        state <= gteCmdPkg::StRun;
                        curOp <= cmdOp;
                    end
                end
                gteCmdPkg::StRun: begin
                    if (lastStep) begin
                        state <= gteCmdPkg::StWrite;
                    end
                end
                // write-back takes one cycle
                default: state <= gteCmdPkg::StIdle;
            endcase
        end
    end

    // accumulator cleared on the start edge, ahead of the first product
    assign clearAcc = cmdStart;
    assign run = state == gteCmdPkg::StRun;
    assign accEn = state == gteCmdPkg::StRun;
    assign resWe = state == gteCmdPkg::StWrite;
    // falls on the write-back edge
    assign busy = state != gteCmdPkg::StIdle;

    // counter terminal count has to line up with the run window
    lastInRun: assert property (@(posedge clk) disable iff (rst)
        lastStep |-> (state == gteCmdPkg::StRun));

endmodule

`default_nettype wire

//--- rtl/gteStepCounter.sv
`default_nettype none

module gteStepCounter (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                run,
    input  var gteCmdPkg::gteOp                curOp,
    output logic [gteCmdPkg::StepWidth-1:0]    step,
    output logic                               lastStep
);

    logic [gteCmdPkg::StepWidth-1:0] termCount;

    // last step index is product count minus one
    always_comb begin
        case (curOp)
            gteCmdPkg::OpAvsz3: termCount = gteCmdPkg::StepsAvsz3 - 1'b1;
            gteCmdPkg::OpAvsz4: termCount = gteCmdPkg::StepsAvsz4 - 1'b1;
            gteCmdPkg::OpNclip: termCount = gteCmdPkg::StepsNclip - 1'b1;
            default: termCount = '0;
        endcase
    end

    assign lastStep = run && (step == termCount);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= '0;
        end else if (!run || lastStep) begin
            // parked at zero for the next command
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/gteDepthMac.sv
`default_nettype none

module gteDepthMac #(
    parameter int AccWidth = 48
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                clearAcc,
    input  wire                                accEn,
    input  wire  [gteCmdPkg::StepWidth-1:0]    step,
    input  var gteCmdPkg::gteOp                curOp,
    input  wire  [gteRegPkg::DataWidth-1:0]    sz0,
    input  wire  [gteRegPkg::DataWidth-1:0]    sz1,
    input  wire  [gteRegPkg::DataWidth-1:0]    sz2,
    input  wire  [gteRegPkg::DataWidth-1:0]    sz3,
    input  wire  [gteRegPkg::DataWidth-1:0]    sxy0,
    input  wire  [gteRegPkg::DataWidth-1:0]    sxy1,
    input  wire  [gteRegPkg::DataWidth-1:0]    sxy2,
    input  wire  [gteRegPkg::DataWidth-1:0]    zsf3,
    input  wire  [gteRegPkg::DataWidth-1:0]    zsf4,
    output logic [gteRegPkg::DataWidth-1:0]    mac0,
    output logic [15:0]                        otz,
    output logic                               writeOtz
);

    // 17-bit signed operands cover signed 16 and unsigned 16 alike
    localparam int OpWidth = 17;
    localparam int ProdWidth = 2 * OpWidth;
    localparam logic signed [AccWidth-1:0] OtzCeil = AccWidth'(gteRegPkg::OtzMax);

    logic signed [OpWidth-1:0] opA;
    logic signed [OpWidth-1:0] opB;
    logic subtract;
    logic signed [ProdWidth-1:0] prod;
    logic signed [AccWidth-1:0] prodExt;
    logic signed [AccWidth-1:0] acc;
    logic signed [AccWidth-1:0] accShift;

    function automatic logic signed [OpWidth-1:0] sExt(input logic [15:0] v);
        return {v[15], v};
    endfunction

    function automatic logic signed [OpWidth-1:0] uExt(input logic [15:0] v);
        return {1'b0, v};
    endfunction

    // operand pair per step; x in low half of sxy, y in high half
    always_comb begin
        opA = '0;
        opB = '0;
        subtract = 1'b0;
        case (curOp)
            gteCmdPkg::OpAvsz3: begin
                // sz0 not part of the three-point average
                opA = sExt(zsf3[15:0]);
                case (step)
                    3'd0: opB = uExt(sz1[15:0]);
                    3'd1: opB = uExt(sz2[15:0]);
                    default: opB = uExt(sz3[15:0]);
                endcase
            end
            gteCmdPkg::OpAvsz4: begin
                opA = sExt(zsf4[15:0]);
                case (step)
                    3'd0: opB = uExt(sz0[15:0]);
                    3'd1: opB = uExt(sz1[15:0]);
                    3'd2: opB = uExt(sz2[15:0]);
                    default: opB = uExt(sz3[15:0]);
                endcase
            end
            gteCmdPkg::OpNclip: begin
                // first three terms add, last three subtract
                subtract = step >= 3'd3;
                case (step)
                    3'd0, 3'd3: opA = sExt(sxy0[15:0]);
                    3'd1, 3'd4: opA = sExt(sxy1[15:0]);
                    default: opA = sExt(sxy2[15:0]);
                endcase
                case (step)
                    3'd0, 3'd5: opB = sExt(sxy1[31:16]);
                    3'd1, 3'd3: opB = sExt(sxy2[31:16]);
                    default: opB = sExt(sxy0[31:16]);
                endcase
            end
            default: begin
                opA = '0;
            end
        endcase
    end

    assign prod = opA * opB;
    // sign-extended to accumulator width
    assign prodExt = prod;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (clearAcc) begin
            acc <= '0;
        end else if (accEn) begin
            acc <= subtract ? acc - prodExt : acc + prodExt;
        end
    end

    assign mac0 = acc[gteRegPkg::DataWidth-1:0];

    // limC: negative floors at 0, ceiling at OtzMax
    assign accShift = acc >>> gteRegPkg::OtzShift;
    always_comb begin
        if (accShift[AccWidth-1]) begin
            otz = '0;
        end else if (accShift > OtzCeil) begin
            otz = gteRegPkg::OtzMax;
        end else begin
            otz = accShift[15:0];
        end
    end

    // only the depth averages touch OTZ
    assign writeOtz = (curOp == gteCmdPkg::OpAvsz3) || (curOp == gteCmdPkg::OpAvsz4);

endmodule

`default_nettype wire

//--- rtl/gteTop.sv
`default_nettype none

module gteTop #(
    parameter int AccWidth = 48
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  cyc,
    input  wire                                  stb,
    input  wire                                  we,
    input  wire  [gteRegPkg::BusAdrWidth-1:0]    adr,
    input  wire  [gteRegPkg::DataWidth-1:0]      datIn,
    output logic [gteRegPkg::DataWidth-1:0]      datOut,
    output logic                                 ack,
    output logic                                 busy
);

    // host side
    logic hostWe;
    logic hostBank;
    logic [gteRegPkg::RegIdxWidth-1:0] hostIdx;
    logic [gteRegPkg::DataWidth-1:0] hostData;
    logic [gteRegPkg::DataWidth-1:0] hostRdData;
    logic cmdStart;
    gteCmdPkg::gteOp cmdOp;

    // sequencing
    gteCmdPkg::gteOp curOp;
    logic run;
    logic clearAcc;
    logic accEn;
    logic resWe;
    logic [gteCmdPkg::StepWidth-1:0] step;
    logic lastStep;

    // operands and results
    logic [gteRegPkg::DataWidth-1:0] sz0, sz1, sz2, sz3;
    logic [gteRegPkg::DataWidth-1:0] sxy0, sxy1, sxy2;
    logic [gteRegPkg::DataWidth-1:0] zsf3, zsf4;
    logic [gteRegPkg::DataWidth-1:0] mac0;
    logic [15:0] otz;
    logic writeOtz;

    gteBusPort busPort (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datIn(datIn), .busy(busy), .hostRdData(hostRdData), .datOut(datOut),
        .ack(ack), .hostWe(hostWe), .hostBank(hostBank), .hostIdx(hostIdx),
        .hostData(hostData), .cmdStart(cmdStart), .cmdOp(cmdOp)
    );

    gteRegFile regFile (
        .clk(clk), .rst(rst), .hostWe(hostWe), .hostBank(hostBank),
        .hostIdx(hostIdx), .hostData(hostData), .hostRdData(hostRdData),
        .resWe(resWe), .writeOtz(writeOtz), .mac0(mac0), .otz(otz),
        .sz0(sz0), .sz1(sz1), .sz2(sz2), .sz3(sz3),
        .sxy0(sxy0), .sxy1(sxy1), .sxy2(sxy2), .zsf3(zsf3), .zsf4(zsf4)
    );

    gteSequencer sequencer (
        .clk(clk), .rst(rst), .cmdStart(cmdStart), .cmdOp(cmdOp),
        .lastStep(lastStep), .run(run), .clearAcc(clearAcc), .accEn(accEn),
        .resWe(resWe), .busy(busy), .curOp(curOp)
    );

    gteStepCounter stepCounter (
        .clk(clk), .rst(rst), .run(run), .curOp(curOp),
        .step(step), .lastStep(lastStep)
    );

    gteDepthMac #(
        .AccWidth(AccWidth)
    ) depthMac (
        .clk(clk), .rst(rst), .clearAcc(clearAcc), .accEn(accEn), .step(step),
        .curOp(curOp), .sz0(sz0), .sz1(sz1), .sz2(sz2), .sz3(sz3),
        .sxy0(sxy0), .sxy1(sxy1), .sxy2(sxy2), .zsf3(zsf3), .zsf4(zsf4),
        .mac0(mac0), .otz(otz), .writeOtz(writeOtz)
    );

endmodule

`default_nettype wire

//--- dv/gteTbTasks.svh
`ifndef GTE_TB_TASKS_SVH
`define GTE_TB_TASKS_SVH

// returns on the falling edge that shows ack, any stall is waited out here
task automatic waitAck();
    @(negedge clk);
    while (!ack) begin
        @(negedge clk);
    end
endtask

// Wishbone classic write, request held until ack
task automatic busWrite(input logic [gteRegPkg::BusAdrWidth-1:0] a,
                        input logic [gteRegPkg::DataWidth-1:0] d);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = a;
    datIn = d;
    waitAck();
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
endtask

// read data is valid together with ack
task automatic busRead(input logic [gteRegPkg::BusAdrWidth-1:0] a,
                       output logic [gteRegPkg::DataWidth-1:0] d);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = a;
    waitAck();
    d = datOut;
    cyc = 1'b0;
    stb = 1'b0;
endtask

// bank select sits in adr bit 5
function automatic logic [6:0] dataAdr(input logic [4:0] idx);
    return {2'b00, idx};
endfunction

function automatic logic [6:0] ctrlAdr(input logic [4:0] idx);
    return {2'b01, idx};
endfunction

// signed scale times unsigned depth, sz0 only counts for the four-point average
function automatic longint refAvsz(input bit four, input logic [31:0] zsf,
                                   input logic [31:0] s0, input logic [31:0] s1,
                                   input logic [31:0] s2, input logic [31:0] s3);
    longint z;
    longint total;
    z = longint'($signed(zsf[15:0]));
    total = z * longint'(s1[15:0]) + z * longint'(s2[15:0]) + z * longint'(s3[15:0]);
    if (four) begin
        total = total + z * longint'(s0[15:0]);
    end
    return total;
endfunction

// triangle area term, x in the low half and y in the high half
function automatic longint refNclip(input logic [31:0] p0, input logic [31:0] p1,
                                    input logic [31:0] p2);
    longint x0;
    longint x1;
    longint x2;
    longint y0;
    longint y1;
    longint y2;
    x0 = longint'($signed(p0[15:0]));
    x1 = longint'($signed(p1[15:0]));
    x2 = longint'($signed(p2[15:0]));
    y0 = longint'($signed(p0[31:16]));
    y1 = longint'($signed(p1[31:16]));
    y2 = longint'($signed(p2[31:16]));
    return x0 * y1 + x1 * y2 + x2 * y0 - x0 * y2 - x1 * y0 - x2 * y1;
endfunction

// limC on the scaled sum
function automatic logic [31:0] refOtz(input longint total);
    longint scaled;
    scaled = total >>> gteRegPkg::OtzShift;
    if (scaled < 0) begin
        return 32'h0;
    end
    if (scaled > longint'(gteRegPkg::OtzMax)) begin
        return 32'(gteRegPkg::OtzMax);
    end
    return 32'(scaled);
endfunction

`endif

//--- dv/gteTb.sv
`default_nettype none

module gteTb;

    localparam int Cases = 6;
    localparam int Fills = 16;
    // beats of the reset sweep, the fills, the readback sweep and the command cases
    localparam int Beats = 65 + Fills + 64 + 1 + 2 * 8 * Cases + 7 * Cases;
    // two clocks per beat plus eight per command stall
    localparam int BusCycles = 8 + 2 * Beats + 8 * 3 * Cases;
    localparam int WatchdogTime = 20 * BusCycles * 10;

    logic clk;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [gteRegPkg::BusAdrWidth-1:0] adr;
    logic [gteRegPkg::DataWidth-1:0] datIn;
    logic [gteRegPkg::DataWidth-1:0] datOut;
    logic ack;
    logic busy;

    gteTop #(
        .AccWidth(48)
    ) UUT (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datIn(datIn), .datOut(datOut), .ack(ack), .busy(busy)
    );

    `include "gteTbTasks.svh"

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else
            failRun($sformatf("FAIL %s expected %h got %h", name, exp, got));
    endtask

    // ack only answers a request still on the bus
    ackWithRequest: assert property (@(posedge clk) disable iff (rst)
        ack |-> (cyc && stb))
        else failRun("ack seen without a pending request");
    // idle port answers one clock later
    ackAfterRequest: assert property (@(posedge clk) disable iff (rst)
        (cyc && stb && !ack && !busy) |=> ack)
        else failRun("request on an idle port was not acked on the next clock");
    // back-pressure while a command runs
    noAckWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |=> !ack)
        else failRun("ack given while a command was running");
    ackIsPulse: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
        else failRun("ack stayed high for more than one clock");

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WatchdogTime);
        failRun("timeout while waiting on the bus");
    end

    // command beat followed right away by a MAC0 read that stalls behind busy
    task automatic runCmd(input gteCmdPkg::gteOp op, output logic [31:0] mac);
        busWrite(gteRegPkg::CmdAdr, 32'(op));
        assert (busy) else failRun("busy did not rise with the command ack");
        busRead(dataAdr(gteRegPkg::IdxMac0), mac);
    endtask

    task automatic depthCase(input gteCmdPkg::gteOp op, input int mode);
        logic [31:0] zsf;
        logic [31:0] sz [4];
        logic [31:0] got;
        longint total;
        zsf = $urandom;
        for (int i = 0; i < 4; i++) begin
            // nonzero depth so the sign of the scale decides the sum
            sz[i] = $urandom | 32'h1;
        end
        if (mode == 0) begin
            // negative scale floors OTZ at zero
            zsf[15] = 1'b1;
        end else if (mode == 1) begin
            // full scale and deep points drive OTZ to the ceiling
            zsf[15:0] = 16'h7FFF;
            for (int i = 0; i < 4; i++) begin
                sz[i][15] = 1'b1;
            end
        end else begin
            // small scale stays inside the clamp
            zsf[15:0] = zsf[15:0] & 16'h01FF;
        end
        if (op == gteCmdPkg::OpAvsz3) begin
            busWrite(ctrlAdr(gteRegPkg::IdxZsf3), zsf);
        end else begin
            busWrite(ctrlAdr(gteRegPkg::IdxZsf4), zsf);
        end
        for (int i = 0; i < 4; i++) begin
            busWrite(dataAdr(gteRegPkg::IdxSz0 + 5'(i)), sz[i]);
        end
        total = refAvsz(op == gteCmdPkg::OpAvsz4, zsf, sz[0], sz[1], sz[2], sz[3]);
        runCmd(op, got);
        checkEq("MAC0", total[31:0], got);
        busRead(dataAdr(gteRegPkg::IdxOtz), got);
        checkEq("OTZ", refOtz(total), got);
    endtask

    task automatic nclipCase();
        logic [31:0] sxy [3];
        logic [31:0] otzOld;
        logic [31:0] got;
        longint area;
        for (int i = 0; i < 3; i++) begin
            sxy[i] = $urandom;
            busWrite(dataAdr(gteRegPkg::IdxSxy0 + 5'(i)), sxy[i]);
        end
        busRead(dataAdr(gteRegPkg::IdxOtz), otzOld);
        area = refNclip(sxy[0], sxy[1], sxy[2]);
        runCmd(gteCmdPkg::OpNclip, got);
        checkEq("MAC0", area[31:0], got);
        // nclip leaves the depth result alone
        busRead(dataAdr(gteRegPkg::IdxOtz), got);
        checkEq("OTZ", otzOld, got);
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] wdata;
        logic [gteRegPkg::BusAdrWidth-1:0] a;
        logic [31:0] model [64];
        void'($urandom(32'h1534_163e));
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datIn = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        // both banks empty after reset and the command address reads zero
        assert (!busy) else failRun("busy high after reset");
        for (int i = 0; i < 64; i++) begin
            busRead(7'(i), got);
            checkEq($sformatf("datOut adr %h", 7'(i)), 32'h0, got);
            model[i] = 32'h0;
        end
        busRead(gteRegPkg::CmdAdr, got);
        checkEq("datOut cmd", 32'h0, got);
        // random words at random places
        for (int i = 0; i < Fills; i++) begin
            a = 7'($urandom_range(0, 63));
            wdata = $urandom;
            busWrite(a, wdata);
            model[a[5:0]] = wdata;
        end
        // every address of both banks read back against the written words
        for (int i = 0; i < 64; i++) begin
            busRead(7'(i), got);
            checkEq($sformatf("datOut adr %h", 7'(i)), model[i], got);
        end
        // empty opcode is acked and starts nothing
        busWrite(gteRegPkg::CmdAdr, 32'(gteCmdPkg::OpNone));
        assert (!busy) else failRun("empty opcode started a command");
        for (int c = 0; c < Cases; c++) begin
            depthCase(gteCmdPkg::OpAvsz3, c);
        end
        for (int c = 0; c < Cases; c++) begin
            depthCase(gteCmdPkg::OpAvsz4, c);
        end
        for (int c = 0; c < Cases; c++) begin
            nclipCase();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
rtl/gteRegPkg.sv
rtl/gteCmdPkg.sv
rtl/gteBusPort.sv
rtl/gteRegFile.sv
rtl/gteSequencer.sv
rtl/gteStepCounter.sv
rtl/gteDepthMac.sv
rtl/gteTop.sv
dv/gteTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the gteTb simulation with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module gteTb -f verilog.f -o gteTbSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/gteTbSim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
